/* bench/scsi_dma_ctrl_assert.sv */
// SCSI DMA controller assertions
`timescale 1ns/1ps
`default_nettype none

module scsi_dma_ctrl_assert (
  input wire                        clk,
  input wire                        rst_n,
  input wire scsi_sm_pkg::sm_ctrl_t ctrl
);

  // Number of assertion failures seen so far
  int fail_count = 0;

  // The FIFO data path moves one way at a time
  a_path_excl: assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.s2f && ctrl.f2s))
    else begin
      fail_count++;
      $error("s2f and f2s are high together");
    end

  // The chip never sees a read and a write pulse at once
  a_rw_excl: assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.re && ctrl.we))
    else begin
      fail_count++;
      $error("re and we are high together");
    end

  // Fill and drain pointers never move on the same edge
  a_inc_excl: assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.incni && ctrl.incno))
    else begin
      fail_count++;
      $error("incni and incno are high together");
    end

  // Reset holds the sequencer in idle where nothing strobes
  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (ctrl == '0))
    else begin
      fail_count++;
      $error("a strobe is high during reset");
    end

endmodule

bind scsi_dma_ctrl scsi_dma_ctrl_assert assert_i (
  .clk   (clk),
  .rst_n (rst_n),
  .ctrl  (ctrl)
);

`default_nettype wire

/* bench/tb_scsi_dma_ctrl.sv */
// SCSI DMA controller testbench
`timescale 1ns/1ps
`default_nettype none

module tb_scsi_dma_ctrl;
  import scsi_sm_pkg::*;

  localparam int FIFO_DEPTH = 8;

  logic        clk;
  logic        rst_n;
  sm_req_t     req;
  sm_ctrl_t    ctrl;
  scsi_state_t state;
  logic [1:0]  byte_lane;
  fifo_stat_t  fifo_stat;

  // Reference model of the sequencer and the FIFO counters
  scsi_state_t m_state;
  int          m_fill;
  int          m_drain;
  logic [1:0]  m_lane;
  integer      seed;
  logic [31:0] rnd;

  scsi_dma_ctrl #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ctrl      (ctrl),
    .state     (state),
    .byte_lane (byte_lane),
    .fifo_stat (fifo_stat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timed out while waiting for %s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Strobe set that each state should show by the state table
  function automatic sm_ctrl_t expect_strobes(input scsi_state_t s);
    sm_ctrl_t c;
    c = '0;
    case (s)
      ST_CRD1, ST_CRD2: begin
        c.scsi_cs = 1'b1;
        c.re      = 1'b1;
      end
      ST_CRD3: begin
        c.s2cpu     = 1'b1;
        c.set_dsack = 1'b1;
      end
      ST_CWR1, ST_CWR2: begin
        c.scsi_cs = 1'b1;
        c.we      = 1'b1;
        c.cpu2s   = 1'b1;
      end
      ST_CWR3: c.set_dsack = 1'b1;
      ST_DIN1, ST_DIN2: begin
        c.dack = 1'b1;
        c.re   = 1'b1;
      end
      ST_DIN3: begin
        c.s2f   = 1'b1;
        c.incbo = 1'b1;
        c.incni = 1'b1;
      end
      ST_DOUT1: begin
        c.f2s   = 1'b1;
        c.incbo = 1'b1;
        c.incno = 1'b1;
      end
      ST_DOUT2, ST_DOUT3: begin
        c.dack = 1'b1;
        c.we   = 1'b1;
      end
      default: c = '0;
    endcase
    return c;
  endfunction

  // One clock edge of the model where the flags are taken before the counters move
  task automatic model_step();
    sm_ctrl_t s;
    logic     full_now;
    logic     empty_now;
    s = expect_strobes(m_state);
    full_now = ((m_fill - m_drain) == FIFO_DEPTH);
    empty_now = (m_fill == m_drain);
    if (s.incbo) m_lane = m_lane + 2'd1;
    if (s.incni) m_fill++;
    if (s.incno) m_drain++;
    case (m_state)
      ST_IDLE: begin
        if (req.cpu_req)
          m_state = req.cpu_read ? ST_CRD1 : ST_CWR1;
        else if (req.dma_en && req.drq && req.dma_dir && !full_now)
          m_state = ST_DIN1;
        else if (req.dma_en && req.drq && !req.dma_dir && !empty_now)
          m_state = ST_DOUT1;
      end
      ST_CRD1:  m_state = ST_CRD2;
      ST_CRD2:  m_state = ST_CRD3;
      ST_CWR1:  m_state = ST_CWR2;
      ST_CWR2:  m_state = ST_CWR3;
      ST_DIN1:  m_state = ST_DIN2;
      ST_DIN2:  m_state = ST_DIN3;
      ST_DOUT1: m_state = ST_DOUT2;
      ST_DOUT2: m_state = ST_DOUT3;
      default:  m_state = ST_IDLE;
    endcase
  endtask

  // Every DUT output against the model, plus any assertion that has fired
  task automatic compare_outputs();
    check_val(32'(state), 32'(m_state), "state");
    check_val(32'(ctrl), 32'(expect_strobes(m_state)), "ctrl");
    check_val(32'(byte_lane), 32'(m_lane), "byte_lane");
    check_val(32'(fifo_stat.full), 32'((m_fill - m_drain) == FIFO_DEPTH), "full");
    check_val(32'(fifo_stat.empty), 32'(m_fill == m_drain), "empty");
    check_val(32'(dut_i.assert_i.fail_count), 32'd0, "assertion failures");
  endtask

  // Outputs are compared on the falling edge where they have settled
  task automatic cycle();
    @(posedge clk);
    model_step();
    @(negedge clk);
    compare_outputs();
  endtask

  // CPU access held until set_dsack shows and then released
  task automatic cpu_access(input sm_req_t r);
    int          n;
    scsi_state_t first;
    first = r.cpu_read ? ST_CRD1 : ST_CWR1;
    r.cpu_req = 1'b1;
    req = r;
    cycle();
    n = 1;
    check_val(32'(state), 32'(first), "first state of CPU cycle");
    while (!ctrl.set_dsack) begin
      if (n >= 10) timeout_fail("set_dsack");
      cycle();
      n++;
    end
    // DSACK belongs to the third step of the cycle
    check_val(32'(n), 32'd3, "cycles until set_dsack");
    r.cpu_req = 1'b0;
    req = r;
    cycle();
    check_val(32'(state), 32'(ST_IDLE), "state after CPU cycle");
  endtask

  // DMA with drq held until the FIFO refuses and the sequencer stays idle
  task automatic burst(input logic dir);
    int n;
    int moved;
    req = '0;
    req.dma_en = 1'b1;
    req.drq = 1'b1;
    req.dma_dir = dir;
    n = 0;
    moved = 0;
    while (!((dir ? fifo_stat.full : fifo_stat.empty) && state == ST_IDLE && n > 0)) begin
      if (n >= 20 * FIFO_DEPTH) timeout_fail(dir ? "FIFO full" : "FIFO empty");
      cycle();
      if (dir ? ctrl.incni : ctrl.incno) moved++;
      n++;
    end
    check_val(32'(moved), 32'(FIFO_DEPTH), "transfers in burst");
    // The request stays up but the FIFO flag keeps the sequencer in idle
    repeat (8) begin
      cycle();
      check_val(32'(state), 32'(ST_IDLE), "state with transfer refused");
    end
  endtask

  initial begin
    int      n;
    sm_req_t r;
    seed = 32'h4d43;
    rst_n = 1'b0;
    req = '0;
    m_state = ST_IDLE;
    m_fill = 0;
    m_drain = 0;
    m_lane = 2'd0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_outputs();

    // Random CPU reads and writes with DMA held off
    repeat (20) begin
      rnd = $random(seed);
      r = rnd[4:0];
      r.dma_en = 1'b0;
      cpu_access(r);
    end

    // Fill the FIFO to full and then drain it to empty
    burst(1'b1);
    burst(1'b0);

    // CPU and DMA asked for together where the CPU goes first
    rnd = $random(seed);
    r = '0;
    r.cpu_read = rnd[0];
    r.dma_en = 1'b1;
    r.drq = 1'b1;
    r.dma_dir = 1'b1;
    cpu_access(r);
    n = 0;
    while (!ctrl.s2f) begin
      if (n >= 10) timeout_fail("DMA after CPU cycle");
      cycle();
      n++;
    end
    req = '0;
    cycle();

    // Long mixed run with every output compared each clock
    repeat (3000) begin
      rnd = $random(seed);
      req = rnd[4:0];
      cycle();
    end
    req = '0;
    repeat (4) cycle();

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
verilog/scsi_sm_pkg.sv
verilog/scsi_sm_state.sv
verilog/scsi_sm_inputs.sv
verilog/scsi_sm_outputs.sv
verilog/fifo_ptrs.sv
verilog/scsi_dma_ctrl.sv
bench/scsi_dma_ctrl_assert.sv
bench/tb_scsi_dma_ctrl.sv

/* verilog/fifo_ptrs.sv */
// FIFO pointers and flags
`timescale 1ns/1ps
`default_nettype none

module fifo_ptrs #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire scsi_sm_pkg::sm_ctrl_t   ctrl,
  output logic [1:0]                   byte_lane,
  output scsi_sm_pkg::fifo_stat_t      fifo_stat
);

  // Pointer width plus one wrap bit to tell full from empty
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  logic [PTR_W:0] fill_ptr;
  logic [PTR_W:0] drain_ptr;

  // The byte lane wraps at four, one step per byte moved
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_lane <= 2'd0;
    end else if (ctrl.incbo) begin
      byte_lane <= byte_lane + 2'd1;
    end
  end

  // Fill side advances after the SCSI to FIFO step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_ptr <= '0;
    end else if (ctrl.incni) begin
      fill_ptr <= fill_ptr + (PTR_W + 1)'(1);
    end
  end

  // Drain side advances after the FIFO to SCSI step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drain_ptr <= '0;
    end else if (ctrl.incno) begin
      drain_ptr <= drain_ptr + (PTR_W + 1)'(1);
    end
  end

  // Full when the fill side is one lap ahead, empty when both sides meet
  always_comb begin
    fifo_stat.empty = (fill_ptr == drain_ptr);
    fifo_stat.full  = (fill_ptr[PTR_W] != drain_ptr[PTR_W]) &&
                      (fill_ptr[PTR_W-1:0] == drain_ptr[PTR_W-1:0]);
  end

endmodule

`default_nettype wire

/* verilog/scsi_dma_ctrl.sv */
// SCSI DMA transfer controller
`timescale 1ns/1ps
`default_nettype none

module scsi_dma_ctrl #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire scsi_sm_pkg::sm_req_t    req,
  output scsi_sm_pkg::sm_ctrl_t        ctrl,
  output scsi_sm_pkg::scsi_state_t     state,
  output logic [1:0]                   byte_lane,
  output scsi_sm_pkg::fifo_stat_t      fifo_stat
);
  import scsi_sm_pkg::*;

  // Loop signals between the two PLA planes and the state flops
  scsi_state_t next_state;
  sm_terms_t   terms;

  // Present state held for one clock
  scsi_sm_state u_state (
    .clk        (clk),
    .rst_n      (rst_n),
    .next_state (next_state),
    .state      (state)
  );

  // Product terms from state, requests and FIFO flags
  scsi_sm_inputs u_inputs (
    .state     (state),
    .req       (req),
    .fifo_stat (fifo_stat),
    .terms     (terms)
  );

  // Next state and strobes as ORs of the terms
  scsi_sm_outputs u_outputs (
    .terms      (terms),
    .next_state (next_state),
    .ctrl       (ctrl)
  );

  // The increment strobes close the loop through full and empty
  fifo_ptrs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo_ptrs (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .byte_lane (byte_lane),
    .fifo_stat (fifo_stat)
  );

endmodule

`default_nettype wire

/* verilog/scsi_sm_inputs.sv */
// SCSI sequencer input plane
`timescale 1ns/1ps
`default_nettype none

module scsi_sm_inputs (
  input  wire scsi_sm_pkg::scsi_state_t state,
  input  wire scsi_sm_pkg::sm_req_t     req,
  input  wire scsi_sm_pkg::fifo_stat_t  fifo_stat,
  output scsi_sm_pkg::sm_terms_t        terms
);
  import scsi_sm_pkg::*;

  // Full five-bit matches of the present state
  logic in_idle;
  logic in_crd1;
  logic in_crd2;
  logic in_crd3;
  logic in_cwr1;
  logic in_cwr2;
  logic in_cwr3;
  logic in_din1;
  logic in_din2;
  logic in_din3;
  logic in_dout1;
  logic in_dout2;
  logic in_dout3;
  // Shared product over the first two write steps with dff2 left open
  logic in_cwr12;
  // DMA request seen in idle with no CPU access waiting
  logic dma_go;

  assign in_idle  = (state == ST_IDLE);
  assign in_crd1  = (state == ST_CRD1);
  assign in_crd2  = (state == ST_CRD2);
  assign in_crd3  = (state == ST_CRD3);
  assign in_cwr1  = (state == ST_CWR1);
  assign in_cwr2  = (state == ST_CWR2);
  assign in_cwr3  = (state == ST_CWR3);
  assign in_din1  = (state == ST_DIN1);
  assign in_din2  = (state == ST_DIN2);
  assign in_din3  = (state == ST_DIN3);
  assign in_dout1 = (state == ST_DOUT1);
  assign in_dout2 = (state == ST_DOUT2);
  assign in_dout3 = (state == ST_DOUT3);
  assign in_cwr12 = ~state.dff5 & ~state.dff4 & state.dff3 & state.dff1;
  assign dma_go   = in_idle & ~req.cpu_req & req.dma_en & req.drq;

  always_comb begin
    // Idle arbitration where a CPU access wins over any DMA request
    terms.e0_n  = ~(in_idle & req.cpu_req & req.cpu_read);
    terms.e1_n  = ~(in_idle & req.cpu_req & ~req.cpu_read);
    // A transfer starts only if the FIFO has room or has data for it
    terms.e2_n  = ~(dma_go & req.dma_dir & ~fifo_stat.full);
    terms.e3_n  = ~(dma_go & ~req.dma_dir & ~fifo_stat.empty);
    // Step advance terms, one per state that does not end a cycle
    terms.e4_n  = ~in_crd1;
    terms.e5_n  = ~in_crd2;
    terms.e6_n  = ~in_cwr1;
    terms.e7_n  = ~in_cwr2;
    terms.e8_n  = ~in_din1;
    terms.e9_n  = ~in_din2;
    terms.e10_n = ~in_dout1;
    terms.e11_n = ~in_dout2;
    // CPU read strobes, with DSACK on its own term in the last step
    terms.e12_n = ~in_crd1;
    terms.e13_n = ~in_crd2;
    terms.e14_n = ~in_crd3;
    terms.e15_n = ~in_crd3;
    // CPU write strobes
    terms.e16_n = ~in_cwr1;
    terms.e17_n = ~in_cwr2;
    // The write data path stays open across both chip select steps
    terms.e18_n = ~in_cwr12;
    terms.e19_n = ~in_cwr3;
    // DMA in strobes, pointer increments split from the data move
    terms.e20_n = ~in_din1;
    terms.e21_n = ~in_din2;
    terms.e22_n = ~in_din3;
    terms.e23_n = ~in_din3;
    // DMA out reads the FIFO first and then writes the chip twice
    terms.e24_n = ~in_dout1;
    terms.e25_n = ~in_dout1;
    terms.e26_n = ~in_dout2;
    terms.e27_n = ~in_dout3;
  end

endmodule

`default_nettype wire

/* verilog/scsi_sm_outputs.sv */
// SCSI sequencer output plane
`timescale 1ns/1ps
`default_nettype none

module scsi_sm_outputs (
  input  wire scsi_sm_pkg::sm_terms_t terms,
  output scsi_sm_pkg::scsi_state_t    next_state,
  output scsi_sm_pkg::sm_ctrl_t       ctrl
);

  // Every output is a NAND of active low terms, so any term that is low raises it
  always_comb begin
    // dff1 is set on entry to a first step and when a first step moves on
    next_state.dff1 = ~(terms.e0_n & terms.e1_n & terms.e2_n & terms.e3_n &
                        terms.e4_n & terms.e6_n & terms.e8_n & terms.e10_n);
    // dff2 is set by every advance out of a first or second step
    next_state.dff2 = ~(terms.e4_n & terms.e5_n & terms.e6_n & terms.e7_n &
                        terms.e8_n & terms.e9_n & terms.e10_n & terms.e11_n);
    // The kind bits are loaded on the start and held until the last step
    next_state.dff3 = ~(terms.e1_n & terms.e6_n & terms.e7_n);
    next_state.dff4 = ~(terms.e2_n & terms.e8_n & terms.e9_n);
    next_state.dff5 = ~(terms.e3_n & terms.e10_n & terms.e11_n);

    // Chip handshake for both DMA directions
    ctrl.dack      = ~(terms.e20_n & terms.e21_n & terms.e26_n & terms.e27_n);
    // Byte lane moves on every byte that enters or leaves the FIFO
    ctrl.incbo     = ~(terms.e23_n & terms.e25_n);
    ctrl.incni     = ~terms.e23_n;
    ctrl.incno     = ~terms.e25_n;
    // Read and write pulses to the SCSI chip
    ctrl.re        = ~(terms.e12_n & terms.e13_n & terms.e20_n & terms.e21_n);
    ctrl.we        = ~(terms.e16_n & terms.e17_n & terms.e26_n & terms.e27_n);
    // Register select only for CPU cycles since DMA uses dack instead
    ctrl.scsi_cs   = ~(terms.e12_n & terms.e13_n & terms.e16_n & terms.e17_n);
    // Ends both kinds of CPU cycle
    ctrl.set_dsack = ~(terms.e15_n & terms.e19_n);
    // Data path steering
    ctrl.s2f       = ~terms.e22_n;
    ctrl.f2s       = ~terms.e24_n;
    ctrl.s2cpu     = ~terms.e14_n;
    ctrl.cpu2s     = ~terms.e18_n;
  end

endmodule

`default_nettype wire

/* verilog/scsi_sm_pkg.sv */
// SCSI sequencer shared types
`default_nettype none

package scsi_sm_pkg;

  // Sequencer state with one bit for each of the five state flops
  typedef struct packed {
    logic dff5;
    logic dff4;
    logic dff3;
    logic dff2;
    logic dff1;
  } scsi_state_t;

  // Bits dff5 to dff3 tell the cycle kind and dff2 and dff1 the step
  // Steps run 01, 11, 10 so the first two steps of a cycle share dff1
  localparam scsi_state_t ST_IDLE  = 5'b00000;
  localparam scsi_state_t ST_CRD1  = 5'b00001;
  localparam scsi_state_t ST_CRD2  = 5'b00011;
  localparam scsi_state_t ST_CRD3  = 5'b00010;
  localparam scsi_state_t ST_CWR1  = 5'b00101;
  localparam scsi_state_t ST_CWR2  = 5'b00111;
  localparam scsi_state_t ST_CWR3  = 5'b00110;
  localparam scsi_state_t ST_DIN1  = 5'b01001;
  localparam scsi_state_t ST_DIN2  = 5'b01011;
  localparam scsi_state_t ST_DIN3  = 5'b01010;
  localparam scsi_state_t ST_DOUT1 = 5'b10001;
  localparam scsi_state_t ST_DOUT2 = 5'b10011;
  localparam scsi_state_t ST_DOUT3 = 5'b10010;

  // Product terms of the PLA, each one low while its product holds
  typedef struct packed {
    logic e0_n, e1_n, e2_n, e3_n;
    logic e4_n, e5_n, e6_n, e7_n;
    logic e8_n, e9_n, e10_n, e11_n;
    logic e12_n, e13_n, e14_n, e15_n;
    logic e16_n, e17_n, e18_n, e19_n;
    logic e20_n, e21_n, e22_n, e23_n;
    logic e24_n, e25_n, e26_n, e27_n;
  } sm_terms_t;

  // Request conditions, dma_dir high means SCSI to memory
  typedef struct packed {
    logic cpu_req;
    logic cpu_read;
    logic dma_en;
    logic dma_dir;
    logic drq;
  } sm_req_t;

  // Control strobes to the SCSI chip, the FIFO and the bus interface
  typedef struct packed {
    logic dack;
    logic incbo;
    logic incni;
    logic incno;
    logic re;
    logic we;
    logic scsi_cs;
    logic set_dsack;
    logic s2f;
    logic f2s;
    logic s2cpu;
    logic cpu2s;
  } sm_ctrl_t;

  // FIFO fill state fed back into the idle arbitration
  typedef struct packed {
    logic full;
    logic empty;
  } fifo_stat_t;

endpackage

`default_nettype wire

/* verilog/scsi_sm_state.sv */
// SCSI sequencer state register
`timescale 1ns/1ps
`default_nettype none

module scsi_sm_state (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire scsi_sm_pkg::scsi_state_t next_state,
  output scsi_sm_pkg::scsi_state_t      state
);
  import scsi_sm_pkg::*;

  // The five flops load the output plane on every edge
  // Reset puts the loop in idle so that no strobe fires before the first request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

endmodule

`default_nettype wire
